// File: bench/decode_golden.txt
# flush pc instr | fu op rd rs1 rs2 imm use_imm use_pc use_zimm is_rv16 illegal
# all columns hex, flush rows are dropped together with the skid contents
0 00001000 002081b3 1 01 03 01 02 00000002 0 0 0 0 0
0 00001004 407302b3 1 02 05 06 07 00000407 0 0 0 0 0
0 00001008 02c58533 2 0f 0a 0b 0c 0000002c 0 0 0 0 0
0 0000100c fff00093 1 01 01 00 00 ffffffff 1 0 0 0 0
0 00001010 4032d213 1 08 04 05 00 00000403 1 0 0 0 0
0 00001014 123453b7 1 01 07 00 00 12345000 1 0 0 0 0
0 00001018 fffff417 1 01 08 00 00 fffff000 1 1 0 0 0
0 0000101c ffc12483 3 19 09 02 00 fffffffc 0 0 0 0 0
0 00001020 fe512c23 4 1e 00 02 05 fffffff8 0 0 0 0 0
0 00001024 00208863 5 0b 00 01 02 00000010 0 0 0 0 0
0 00001028 fe019ce3 5 0c 00 03 00 fffffff8 0 0 0 0 0
0 0000102c 001000ef 5 1f 01 00 00 00000800 0 0 0 0 0
0 00001030 00008067 5 20 00 01 00 00000000 0 0 0 0 0
1 00001034 fff00093 1 01 01 00 00 ffffffff 1 0 0 0 0
0 00001038 00000073 6 21 00 00 00 00000000 0 0 0 0 0
0 0000103c 30200073 6 22 00 00 00 00000302 0 0 0 0 0
0 00001040 0ff0000f 6 23 00 00 00 000000ff 0 0 0 0 0
0 00001044 0000100f 6 24 00 00 00 00000000 0 0 0 0 0
0 00001048 300022f3 6 26 05 00 00 00000300 0 0 0 0 0
0 0000104c 3052d073 6 25 00 05 00 00000305 0 0 1 0 0
0 00001050 341130f3 6 28 01 02 00 00000341 0 0 0 0 0
0 00001054 ffffffff 0 00 00 00 00 ffffffff 0 0 0 0 1
0 00001058 04000033 1 00 00 00 00 00000040 0 0 0 0 1
0 0000105c 000010fd 1 01 01 01 00 ffffffff 1 0 0 1 0
0 0000105e 00004144 3 19 09 0a 00 00000004 0 0 0 1 0
0 00001060 0000a011 5 1f 00 00 00 00000004 0 0 0 1 0
0 00001062 0000c401 5 0b 00 08 00 00000008 0 0 0 1 0
0 00001064 0000908a 1 01 01 01 02 00000002 0 0 0 1 0
0 00001066 00008082 5 20 00 01 00 00000000 0 0 0 1 0
0 00001068 00004322 3 19 06 02 00 00000008 0 0 0 1 0
0 0000106a 0000c61e 4 1e 00 02 07 0000000c 0 0 0 1 0
0 0000106c 00008c65 1 0a 08 08 09 00000009 0 0 0 1 0
0 0000106e 00009002 6 00 00 00 00 00000001 0 0 0 1 0
0 00001070 00000000 0 00 00 00 00 00000000 0 0 0 1 1
1 00001072 00008082 5 20 00 01 00 00000000 0 0 0 1 0
0 00001074 00002000 0 00 00 00 00 00000000 0 0 0 1 1

// File: project.f
+incdir+logic
logic/decode_pkg.sv
logic/rvc_expander.sv
logic/rv32_decoder.sv
logic/decode_skid.sv
logic/decode_stage.sv
bench/decode_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/decode_pkg.sv
      - logic/rvc_expander.sv
      - logic/rv32_decoder.sv
      - logic/decode_skid.sv
      - logic/decode_stage.sv
  - target: test
    files:
      - bench/decode_tb.sv

// File: bench/decode_tb.sv
`timescale 1ns/1ns

module decode_tb;

    localparam int MAX_VEC = 64;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 in_valid;
    logic                 in_ready;
    decode_pkg::word_t    in_pc;
    decode_pkg::instr_t   in_instr;
    logic                 out_valid;
    logic                 out_ready;
    decode_pkg::word_t    out_pc;
    decode_pkg::fu_e      out_fu;
    decode_pkg::op_e      out_op;
    decode_pkg::reg_idx_t out_rd;
    decode_pkg::reg_idx_t out_rs1;
    decode_pkg::reg_idx_t out_rs2;
    decode_pkg::word_t    out_imm;
    logic                 out_use_imm;
    logic                 out_use_pc;
    logic                 out_use_zimm;
    logic                 out_is_rv16;
    logic                 out_illegal;

    // golden columns, one row per vector.
    logic [31:0] vec [MAX_VEC][14];
    int          errs;

    decode_stage dut_i (.*);

    always #10 clk = ~clk;

    task automatic check_word(input string name, input decode_pkg::word_t exp,
                              input decode_pkg::word_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_fu(input string name, input decode_pkg::fu_e exp,
                            input decode_pkg::fu_e act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_op(input string name, input decode_pkg::op_e exp,
                            input decode_pkg::op_e act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_reg(input string name, input decode_pkg::reg_idx_t exp,
                             input decode_pkg::reg_idx_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic compare_record(input int i);
        check_word("out_pc", vec[i][1], out_pc);
        check_fu("out_fu", decode_pkg::fu_e'(vec[i][3][2:0]), out_fu);
        check_op("out_op", decode_pkg::op_e'(vec[i][4][5:0]), out_op);
        check_reg("out_rd", vec[i][5][4:0], out_rd);
        check_reg("out_rs1", vec[i][6][4:0], out_rs1);
        check_reg("out_rs2", vec[i][7][4:0], out_rs2);
        check_word("out_imm", vec[i][8], out_imm);
        check_flag("out_use_imm", vec[i][9][0], out_use_imm);
        check_flag("out_use_pc", vec[i][10][0], out_use_pc);
        check_flag("out_use_zimm", vec[i][11][0], out_use_zimm);
        check_flag("out_is_rv16", vec[i][12][0], out_is_rv16);
        check_flag("out_illegal", vec[i][13][0], out_illegal);
    endtask

    initial begin
        int          fd;
        int          n;
        int          nvec;
        int          next;
        int          idx;
        int          cycles;
        int          limit;
        int          passed;
        int          failed;
        int          seed;
        logic        held;
        logic        timed_out;
        logic [92:0] snap;
        logic [92:0] held_snap;
        string       line;
        int          exp_q[$];

        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_instr  = '0;
        out_ready = 1'b0;
        seed      = 32'haa3c_b785;
        nvec      = 0;
        next      = 0;
        cycles    = 0;
        passed    = 0;
        failed    = 0;
        held      = 1'b0;
        timed_out = 1'b0;
        held_snap = '0;

        fd = $fopen("bench/decode_golden.txt", "r");
        if (fd == 0) begin
            $display("golden vector file could not be opened");
            failed++;
        end else begin
            while (!$feof(fd) && nvec < MAX_VEC) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                vec[nvec][0], vec[nvec][1], vec[nvec][2], vec[nvec][3],
                                vec[nvec][4], vec[nvec][5], vec[nvec][6], vec[nvec][7],
                                vec[nvec][8], vec[nvec][9], vec[nvec][10], vec[nvec][11],
                                vec[nvec][12], vec[nvec][13]);
                    if (n == 14) nvec++;
                end
            end
            $fclose(fd);
        end
        limit = nvec * 8 + 50;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errs = 0;
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("in_ready", 1'b1, in_ready);
        if (errs == 0) begin
            passed++;
            $display("reset test ok");
        end else begin
            failed++;
            $display("reset test mismatch");
        end

        while ((next < nvec || exp_q.size() != 0) && !timed_out) begin
            @(posedge clk);
            cycles++;
            snap = {out_pc, out_fu, out_op, out_rd, out_rs1, out_rs2, out_imm,
                    out_use_imm, out_use_pc, out_use_zimm, out_is_rv16, out_illegal};
            if (held && out_valid && snap !== held_snap) begin
                $display("output fields changed while stalled");
                failed++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output gave a record that was never expected");
                    failed++;
                end else begin
                    idx  = exp_q.pop_front();
                    errs = 0;
                    compare_record(idx);
                    if (errs == 0) begin
                        passed++;
                        $display("test %0d pc %h ok", idx, out_pc);
                    end else begin
                        failed++;
                        $display("test %0d pc %h mismatch", idx, out_pc);
                    end
                end
            end
            held      = out_valid && !out_ready;
            held_snap = snap;
            if (in_valid && in_ready && !flush) exp_q.push_back(next);
            if (in_valid && in_ready) next++;
            if (flush) begin // whatever was still inside is gone.
                exp_q.delete();
                held = 1'b0;
            end

            if (next < nvec && ($random(seed) & 3) != 0) begin
                in_valid <= 1'b1;
                in_pc    <= vec[next][1];
                in_instr <= vec[next][2];
                flush    <= vec[next][0][0];
            end else begin
                in_valid <= 1'b0;
                flush    <= 1'b0;
            end
            out_ready <= (($random(seed) & 3) != 0);

            if (cycles >= limit) begin
                $display("output stalled, run stopped after %0d cycles", cycles);
                failed++;
                timed_out = 1'b1;
            end
        end

        $display("%0d passed, %0d failed", passed, failed);
        if (failed == 0 && passed > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::word_t    in_pc,
    input  decode_pkg::instr_t   in_instr,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::word_t    out_pc,
    output decode_pkg::fu_e      out_fu,
    output decode_pkg::op_e      out_op,
    output decode_pkg::reg_idx_t out_rd,
    output decode_pkg::reg_idx_t out_rs1,
    output decode_pkg::reg_idx_t out_rs2,
    output decode_pkg::word_t    out_imm,
    output logic                 out_use_imm,
    output logic                 out_use_pc,
    output logic                 out_use_zimm,
    output logic                 out_is_rv16,
    output logic                 out_illegal
);

    logic                 is_rv16;
    logic                 rvc_err;
    decode_pkg::instr_t   exp_instr;
    decode_pkg::instr_t   dec_instr;
    decode_pkg::word_t    d_pc;
    decode_pkg::fu_e      d_fu;
    decode_pkg::op_e      d_op;
    decode_pkg::reg_idx_t d_rd;
    decode_pkg::reg_idx_t d_rs1;
    decode_pkg::reg_idx_t d_rs2;
    decode_pkg::word_t    d_imm;
    logic                 d_use_imm;
    logic                 d_use_pc;
    logic                 d_use_zimm;
    logic                 d_is_rv16;
    logic                 d_illegal;

    assign is_rv16   = (in_instr[1:0] != 2'b11);
    assign dec_instr = is_rv16 ? exp_instr : in_instr;

    rvc_expander rvc_expander_i (
        .cinstr  (in_instr[15:0]),
        .instr   (exp_instr),
        .rvc_err (rvc_err)
    );

    rv32_decoder rv32_decoder_i (
        .id_pc       (in_pc),
        .instr       (dec_instr),
        .is_rv16     (is_rv16),
        .rv16_err    (is_rv16 & rvc_err), // only valid for compressed words.
        .pc          (d_pc),
        .fu          (d_fu),
        .op          (d_op),
        .rd          (d_rd),
        .rs1         (d_rs1),
        .rs2         (d_rs2),
        .imm         (d_imm),
        .use_imm     (d_use_imm),
        .use_pc      (d_use_pc),
        .use_zimm    (d_use_zimm),
        .is_rv16_out (d_is_rv16),
        .rv32_err    (d_illegal)
    );

    decode_skid decode_skid_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (d_pc),
        .in_fu        (d_fu),
        .in_op        (d_op),
        .in_rd        (d_rd),
        .in_rs1       (d_rs1),
        .in_rs2       (d_rs2),
        .in_imm       (d_imm),
        .in_use_imm   (d_use_imm),
        .in_use_pc    (d_use_pc),
        .in_use_zimm  (d_use_zimm),
        .in_is_rv16   (d_is_rv16),
        .in_illegal   (d_illegal),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_fu       (out_fu),
        .out_op       (out_op),
        .out_rd       (out_rd),
        .out_rs1      (out_rs1),
        .out_rs2      (out_rs2),
        .out_imm      (out_imm),
        .out_use_imm  (out_use_imm),
        .out_use_pc   (out_use_pc),
        .out_use_zimm (out_use_zimm),
        .out_is_rv16  (out_is_rv16),
        .out_illegal  (out_illegal)
    );

endmodule

// File: logic/decode_skid.sv
`timescale 1ns/1ns

module decode_skid (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::word_t    in_pc,
    input  decode_pkg::fu_e      in_fu,
    input  decode_pkg::op_e      in_op,
    input  decode_pkg::reg_idx_t in_rd,
    input  decode_pkg::reg_idx_t in_rs1,
    input  decode_pkg::reg_idx_t in_rs2,
    input  decode_pkg::word_t    in_imm,
    input  logic                 in_use_imm,
    input  logic                 in_use_pc,
    input  logic                 in_use_zimm,
    input  logic                 in_is_rv16,
    input  logic                 in_illegal,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::word_t    out_pc,
    output decode_pkg::fu_e      out_fu,
    output decode_pkg::op_e      out_op,
    output decode_pkg::reg_idx_t out_rd,
    output decode_pkg::reg_idx_t out_rs1,
    output decode_pkg::reg_idx_t out_rs2,
    output decode_pkg::word_t    out_imm,
    output logic                 out_use_imm,
    output logic                 out_use_pc,
    output logic                 out_use_zimm,
    output logic                 out_is_rv16,
    output logic                 out_illegal
);

    localparam int REC_W = 2 * $bits(decode_pkg::word_t) + 3 * $bits(decode_pkg::reg_idx_t)
                         + $bits(decode_pkg::fu_e) + $bits(decode_pkg::op_e) + 5;

    logic [REC_W-1:0]                   in_rec;
    logic [REC_W-1:0]                   main_rec;
    logic [REC_W-1:0]                   skid_rec;
    logic                               main_valid;
    logic                               skid_valid;
    logic                               main_load;
    logic [$bits(decode_pkg::fu_e)-1:0] fu_bits;
    logic [$bits(decode_pkg::op_e)-1:0] op_bits;

    assign in_rec = {in_pc, in_fu, in_op, in_rd, in_rs1, in_rs2, in_imm,
                     in_use_imm, in_use_pc, in_use_zimm, in_is_rv16, in_illegal};

    assign in_ready  = ~skid_valid; // straight from a flop.
    assign out_valid = main_valid;
    assign main_load = ~main_valid | out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= skid_valid | in_valid; // skid drains first.
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) main_rec <= skid_valid ? skid_rec : in_rec;
        if (!main_load && in_ready) skid_rec <= in_rec;
    end

    assign {out_pc, fu_bits, op_bits, out_rd, out_rs1, out_rs2, out_imm,
            out_use_imm, out_use_pc, out_use_zimm, out_is_rv16, out_illegal} = main_rec;
    assign out_fu = decode_pkg::fu_e'(fu_bits);
    assign out_op = decode_pkg::op_e'(op_bits);

endmodule

// File: logic/rv32_decoder.sv
`timescale 1ns/1ns
`include "decode_consts.svh"

module rv32_decoder (
    input  decode_pkg::word_t    id_pc,
    input  decode_pkg::instr_t   instr,
    input  logic                 is_rv16,
    input  logic                 rv16_err,
    output decode_pkg::word_t    pc,
    output decode_pkg::fu_e      fu,
    output decode_pkg::op_e      op,
    output decode_pkg::reg_idx_t rd,
    output decode_pkg::reg_idx_t rs1,
    output decode_pkg::reg_idx_t rs2,
    output decode_pkg::word_t    imm,
    output logic                 use_imm,
    output logic                 use_pc,
    output logic                 use_zimm,
    output logic                 is_rv16_out,
    output logic                 rv32_err
);

    decode_pkg::word_t imm_u;
    decode_pkg::word_t imm_i;
    decode_pkg::word_t imm_s;
    decode_pkg::word_t imm_b;
    decode_pkg::word_t imm_j;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        pc          = id_pc;
        is_rv16_out = is_rv16;
        fu          = decode_pkg::FU_NONE;
        op          = decode_pkg::OP_NONE;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = imm_i;
        use_imm     = 1'b0;
        use_pc      = 1'b0;
        use_zimm    = 1'b0;
        rv32_err    = rv16_err; // expander error carried through.
        case (instr[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                imm     = imm_u;
                use_imm = 1'b1;
                use_pc  = (instr[6:0] == `OPC_AUIPC);
                fu      = decode_pkg::FU_ALU;
                op      = decode_pkg::ALU_ADD;
                rd      = instr[11:7];
            end
            `OPC_OP: begin
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                rd  = instr[11:7];
                fu  = (funct7 == 7'b0000001) ? decode_pkg::FU_MDU : decode_pkg::FU_ALU;
                case ({funct7, funct3})
                    {7'h00, 3'd0}: op = decode_pkg::ALU_ADD;
                    {7'h20, 3'd0}: op = decode_pkg::ALU_SUB;
                    {7'h00, 3'd1}: op = decode_pkg::ALU_SLL;
                    {7'h00, 3'd2}: op = decode_pkg::ALU_LT;
                    {7'h00, 3'd3}: op = decode_pkg::ALU_LTU;
                    {7'h00, 3'd4}: op = decode_pkg::ALU_XOR;
                    {7'h00, 3'd5}: op = decode_pkg::ALU_SRL;
                    {7'h20, 3'd5}: op = decode_pkg::ALU_SRA;
                    {7'h00, 3'd6}: op = decode_pkg::ALU_OR;
                    {7'h00, 3'd7}: op = decode_pkg::ALU_AND;
                    {7'h01, 3'd0}: op = decode_pkg::MDU_MUL;
                    {7'h01, 3'd1}: op = decode_pkg::MDU_MULH;
                    {7'h01, 3'd2}: op = decode_pkg::MDU_MULHSU;
                    {7'h01, 3'd3}: op = decode_pkg::MDU_MULHU;
                    {7'h01, 3'd4}: op = decode_pkg::MDU_DIV;
                    {7'h01, 3'd5}: op = decode_pkg::MDU_DIVU;
                    {7'h01, 3'd6}: op = decode_pkg::MDU_REM;
                    {7'h01, 3'd7}: op = decode_pkg::MDU_REMU;
                    default: rv32_err = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                fu      = decode_pkg::FU_ALU;
                use_imm = 1'b1;
                rs1     = instr[19:15];
                rd      = instr[11:7];
                case (funct3)
                    3'd0: op = decode_pkg::ALU_ADD;
                    3'd2: op = decode_pkg::ALU_LT;
                    3'd3: op = decode_pkg::ALU_LTU;
                    3'd4: op = decode_pkg::ALU_XOR;
                    3'd6: op = decode_pkg::ALU_OR;
                    3'd7: op = decode_pkg::ALU_AND;
                    3'd1: begin
                        op       = decode_pkg::ALU_SLL;
                        rv32_err = (funct7 != 7'h00);
                    end
                    default: begin // shift right, funct7 picks arithmetic.
                        op       = funct7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                        rv32_err = ({funct7[6], funct7[4:0]} != '0);
                    end
                endcase
                rv32_err = rv32_err | rv16_err;
            end
            `OPC_LOAD: begin
                fu  = decode_pkg::FU_LOAD;
                rs1 = instr[19:15];
                rd  = instr[11:7];
                case (funct3)
                    3'd0: op = decode_pkg::LSU_LB;
                    3'd1: op = decode_pkg::LSU_LH;
                    3'd2: op = decode_pkg::LSU_LW;
                    3'd4: op = decode_pkg::LSU_LBU;
                    3'd5: op = decode_pkg::LSU_LHU;
                    default: rv32_err = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                imm = imm_s;
                fu  = decode_pkg::FU_STORE;
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                case (funct3)
                    3'd0: op = decode_pkg::LSU_SB;
                    3'd1: op = decode_pkg::LSU_SH;
                    3'd2: op = decode_pkg::LSU_SW;
                    default: rv32_err = 1'b1;
                endcase
            end
            `OPC_JAL: begin
                imm = imm_j;
                fu  = decode_pkg::FU_BU;
                op  = decode_pkg::CF_JAL;
                rd  = instr[11:7];
            end
            `OPC_JALR: begin
                fu  = decode_pkg::FU_BU;
                op  = decode_pkg::CF_JALR;
                rs1 = instr[19:15];
                rd  = instr[11:7];
                if (funct3 != 3'd0) rv32_err = 1'b1;
            end
            `OPC_BRANCH: begin
                imm = imm_b;
                fu  = decode_pkg::FU_BU;
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                case (funct3)
                    3'd0: op = decode_pkg::ALU_EQ;
                    3'd1: op = decode_pkg::ALU_NE;
                    3'd4: op = decode_pkg::ALU_LT;
                    3'd5: op = decode_pkg::ALU_GE;
                    3'd6: op = decode_pkg::ALU_LTU;
                    3'd7: op = decode_pkg::ALU_GEU;
                    default: rv32_err = 1'b1;
                endcase
            end
            `OPC_SYSTEM: begin
                fu  = decode_pkg::FU_CSR;
                rs1 = instr[19:15];
                rd  = instr[11:7];
                if (funct3 == 3'd0) begin
                    if ({instr[19:15], instr[11:7]} != '0) begin
                        rv32_err = 1'b1;
                    end else begin
                        case (instr[31:20])
                            12'h000: op = decode_pkg::CF_ECALL;
                            12'h001, 12'h105: ; // ebreak and wfi pass as no-ops.
                            12'h302: op = decode_pkg::CF_MRET;
                            default: rv32_err = 1'b1;
                        endcase
                    end
                end else begin
                    use_zimm = funct3[2];
                    case (funct3[1:0])
                        2'd1: op = decode_pkg::CSR_WRITE;
                        2'd2: op = (rs1 == '0) ? decode_pkg::CSR_READ : decode_pkg::CSR_SET;
                        2'd3: op = (rs1 == '0) ? decode_pkg::CSR_READ : decode_pkg::CSR_CLEAR;
                        default: rv32_err = 1'b1;
                    endcase
                end
            end
            `OPC_MISC_MEM: begin
                fu = decode_pkg::FU_CSR;
                case (funct3)
                    3'd0: op = decode_pkg::CF_FENCE;
                    3'd1: op = decode_pkg::CF_FENCE_I;
                    default: rv32_err = 1'b1;
                endcase
            end
            default: rv32_err = 1'b1;
        endcase
    end

endmodule

// File: logic/rvc_expander.sv
`timescale 1ns/1ns
`include "decode_consts.svh"

module rvc_expander (
    input  decode_pkg::cinstr_t cinstr,
    output decode_pkg::instr_t  instr,
    output logic                rvc_err
);

    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    logic [4:0]  rs1_p;
    logic [4:0]  rs2_p;
    logic [11:0] imm6_sx;
    logic [20:0] j_off;
    logic [12:0] b_off;

    assign rd_full  = cinstr[11:7];
    assign rs2_full = cinstr[6:2];
    assign rs1_p    = {2'b01, cinstr[9:7]}; // x8..x15.
    assign rs2_p    = {2'b01, cinstr[4:2]};
    assign imm6_sx  = {{7{cinstr[12]}}, cinstr[6:2]};

    // scrambled c.j / c.jal offset.
    assign j_off = {{10{cinstr[12]}}, cinstr[8], cinstr[10:9], cinstr[6], cinstr[7],
                    cinstr[2], cinstr[11], cinstr[5:3], 1'b0};
    assign b_off = {{5{cinstr[12]}}, cinstr[6:5], cinstr[2], cinstr[11:10], cinstr[4:3], 1'b0};

    always_comb begin
        instr   = '0;
        rvc_err = 1'b0;
        case ({cinstr[1:0], cinstr[15:13]})
            5'b00_000: begin // c.addi4spn
                instr = {2'b00, cinstr[10:7], cinstr[12:11], cinstr[5], cinstr[6], 2'b00,
                         5'd2, 3'b000, rs2_p, `OPC_OP_IMM};
                rvc_err = (cinstr[12:5] == '0);
            end
            5'b00_010: instr = {5'b0, cinstr[5], cinstr[12:10], cinstr[6], 2'b00,
                                rs1_p, 3'b010, rs2_p, `OPC_LOAD};
            5'b00_110: instr = {5'b0, cinstr[5], cinstr[12], rs2_p, rs1_p, 3'b010,
                                cinstr[11:10], cinstr[6], 2'b00, `OPC_STORE};
            5'b01_000: instr = {imm6_sx, rd_full, 3'b000, rd_full, `OPC_OP_IMM};
            5'b01_001: instr = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd1, `OPC_JAL};
            5'b01_010: instr = {imm6_sx, 5'd0, 3'b000, rd_full, `OPC_OP_IMM};
            5'b01_011: begin
                rvc_err = ({cinstr[12], cinstr[6:2]} == '0);
                if (rd_full == 5'd2) begin // c.addi16sp.
                    instr = {{3{cinstr[12]}}, cinstr[4:3], cinstr[5], cinstr[2], cinstr[6],
                             4'b0000, 5'd2, 3'b000, 5'd2, `OPC_OP_IMM};
                end else begin
                    instr = {{15{cinstr[12]}}, cinstr[6:2], rd_full, `OPC_LUI};
                end
            end
            5'b01_100: begin
                case (cinstr[11:10])
                    2'b00: instr = {7'b0000000, cinstr[6:2], rs1_p, 3'b101, rs1_p, `OPC_OP_IMM};
                    2'b01: instr = {7'b0100000, cinstr[6:2], rs1_p, 3'b101, rs1_p, `OPC_OP_IMM};
                    2'b10: instr = {imm6_sx, rs1_p, 3'b111, rs1_p, `OPC_OP_IMM};
                    default: begin
                        case (cinstr[6:5])
                            2'b00: instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, `OPC_OP};
                            2'b01: instr = {7'b0000000, rs2_p, rs1_p, 3'b100, rs1_p, `OPC_OP};
                            2'b10: instr = {7'b0000000, rs2_p, rs1_p, 3'b110, rs1_p, `OPC_OP};
                            default: instr = {7'b0000000, rs2_p, rs1_p, 3'b111, rs1_p, `OPC_OP};
                        endcase
                    end
                endcase
                // shamt[5] and the rv64 word ops are reserved here.
                rvc_err = cinstr[12] && (cinstr[11:10] != 2'b10);
            end
            5'b01_101: instr = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd0, `OPC_JAL};
            5'b01_110: instr = {b_off[12], b_off[10:5], 5'd0, rs1_p, 3'b000,
                                b_off[4:1], b_off[11], `OPC_BRANCH};
            5'b01_111: instr = {b_off[12], b_off[10:5], 5'd0, rs1_p, 3'b001,
                                b_off[4:1], b_off[11], `OPC_BRANCH};
            5'b10_000: begin
                instr   = {7'b0000000, cinstr[6:2], rd_full, 3'b001, rd_full, `OPC_OP_IMM};
                rvc_err = cinstr[12];
            end
            5'b10_010: begin
                instr   = {4'b0000, cinstr[3:2], cinstr[12], cinstr[6:4], 2'b00,
                           5'd2, 3'b010, rd_full, `OPC_LOAD};
                rvc_err = (rd_full == '0);
            end
            5'b10_100: begin
                if (!cinstr[12]) begin
                    if (rs2_full == '0) begin // c.jr
                        instr   = {12'h000, rd_full, 3'b000, 5'd0, `OPC_JALR};
                        rvc_err = (rd_full == '0);
                    end else begin
                        instr = {7'b0000000, rs2_full, 5'd0, 3'b000, rd_full, `OPC_OP};
                    end
                end else if (rs2_full != '0) begin
                    instr = {7'b0000000, rs2_full, rd_full, 3'b000, rd_full, `OPC_OP};
                end else if (rd_full == '0) begin
                    instr = {12'h001, 5'd0, 3'b000, 5'd0, `OPC_SYSTEM}; // ebreak.
                end else begin
                    instr = {12'h000, rd_full, 3'b000, 5'd1, `OPC_JALR}; // c.jalr
                end
            end
            5'b10_110: instr = {4'b0000, cinstr[8:7], cinstr[12], rs2_full, 5'd2, 3'b010,
                                cinstr[11:9], 2'b00, `OPC_STORE};
            default: rvc_err = 1'b1;
        endcase
        if (rvc_err) instr = '0;
    end

endmodule

// File: logic/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [31:0]           instr_t;
    typedef logic [15:0]           cinstr_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        FU_NONE,
        FU_ALU,
        FU_MDU,
        FU_LOAD,
        FU_STORE,
        FU_BU,
        FU_CSR
    } fu_e;

    // zero is the empty operation.
    typedef enum logic [5:0] {
        OP_NONE = 6'd0,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_LT,
        ALU_LTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,
        ALU_NE,
        ALU_GE,
        ALU_GEU,
        MDU_MUL,
        MDU_MULH,
        MDU_MULHSU,
        MDU_MULHU,
        MDU_DIV,
        MDU_DIVU,
        MDU_REM,
        MDU_REMU,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW,
        CF_JAL,
        CF_JALR,
        CF_ECALL,
        CF_MRET,
        CF_FENCE,
        CF_FENCE_I,
        CSR_WRITE,
        CSR_READ,
        CSR_SET,
        CSR_CLEAR
    } op_e;

endpackage

// File: logic/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN      32
`define REG_IDX_W 5

// rv32 major opcodes.
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_SYSTEM   7'b1110011
`define OPC_MISC_MEM 7'b0001111

`endif
